/* bimodal_predictor.f */
hw/bpred_pkg.sv
hw/branch_decoder.sv
hw/pattern_history_table.sv
hw/branch_target_buffer.sv
hw/bimodal_predictor.sv
sim/tb_bimodal_predictor.sv

/* hw/bimodal_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

// Bimodal predictor for the fetch stage, trained from the memory stage
module bimodal_predictor #(
    parameter int PHT_INDEX_BITS = 8,
    parameter int BTB_INDEX_BITS = 6
) (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         flush,
    input  wire bpred_pkg::instr_word_t instr,
    input  wire bpred_pkg::addr_t       instr_addr,
    input  wire bpred_pkg::instr_word_t resolved_instr,
    input  wire bpred_pkg::addr_t       resolved_addr,
    input  wire                         resolved_taken,
    input  wire bpred_pkg::addr_t       resolved_target,
    output logic                        taken,
    output bpred_pkg::addr_t            taken_addr
);

    import bpred_pkg::*;

    logic  fetch_is_branch;
    logic  fetch_is_jump;
    logic  resolve_is_branch;
    logic  pht_taken;
    logic  btb_hit;
    addr_t btb_target;
    logic  taken_next;

    branch_decoder decode_fetch (
        .instr     (instr),
        .is_branch (fetch_is_branch),
        .is_jump   (fetch_is_jump)
    );

    // Jumps and branches train the same way, so only is_branch matters here
    branch_decoder decode_resolve (
        .instr     (resolved_instr),
        .is_branch (resolve_is_branch),
        .is_jump   ()
    );

    pattern_history_table #(
        .PHT_INDEX_BITS (PHT_INDEX_BITS)
    ) pht0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .lookup_en     (fetch_is_branch),
        .lookup_addr   (instr_addr),
        .predict_taken (pht_taken),
        .update_en     (resolve_is_branch),  // A resolved non-branch leaves the counters alone
        .update_addr   (resolved_addr),
        .update_taken  (resolved_taken)
    );

    branch_target_buffer #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) btb0 (
        .CLK          (CLK),
        .RESET        (RESET),
        .lookup_en    (fetch_is_branch),
        .lookup_addr  (instr_addr),
        .hit          (btb_hit),
        .target       (btb_target),
        .write_en     (resolve_is_branch & resolved_taken),  // Only taken outcomes carry a target
        .write_addr   (resolved_addr),
        .write_target (resolved_target)
    );

    // A direct jump is always taken once its target is known
    assign taken_next = fetch_is_jump ? btb_hit : (pht_taken & btb_hit);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            taken      <= 1'b0;
            taken_addr <= '0;
        end else if (flush) begin
            taken      <= 1'b0;             // Wrong-path fetch, drop the prediction
            taken_addr <= '0;
        end else begin
            taken      <= taken_next;
            taken_addr <= btb_target;       // Already zero on a miss
        end
    end

endmodule

`default_nettype wire

/* hw/bpred_pkg.sv */
`default_nettype none

package bpred_pkg;

    // Program counter or target address
    typedef logic [31:0] addr_t;

    // Major opcodes of the instructions the predictor tracks
    typedef enum logic [5:0] {
        OP_REGIMM = 6'd1,                   // bltz, bgez and the linking forms, split by rt
        OP_J      = 6'd2,
        OP_JAL    = 6'd3,
        OP_BEQ    = 6'd4,
        OP_BNE    = 6'd5,
        OP_BLEZ   = 6'd6,
        OP_BGTZ   = 6'd7
    } opcode_t;

    // rt values that make a REGIMM word a real branch and not a trap
    localparam logic [4:0] RT_BLTZ   = 5'd0;
    localparam logic [4:0] RT_BGEZ   = 5'd1;
    localparam logic [4:0] RT_BLTZAL = 5'd16;
    localparam logic [4:0] RT_BGEZAL = 5'd17;

    // I-type layout, used by the conditional branches
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;                   // Word offset from the delay slot
    } i_fields_t;

    // J-type layout, used by j and jal
    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;                 // Word index inside the current 256 MB region
    } j_fields_t;

    // One instruction word, read either as I-type or as J-type
    typedef union packed {
        i_fields_t i_fields;
        j_fields_t j_fields;
    } instr_word_t;

    // Two-bit saturating counter, bit 1 is the taken decision
    typedef logic [1:0] counter_t;

    localparam counter_t CNT_STRONG_NT = 2'd0;
    localparam counter_t CNT_WEAK_NT   = 2'd1;
    localparam counter_t CNT_WEAK_T    = 2'd2;
    localparam counter_t CNT_STRONG_T  = 2'd3;

    // A fresh counter leans not taken but flips after one taken outcome
    localparam counter_t CNT_RESET     = CNT_WEAK_NT;

endpackage

`default_nettype wire

/* hw/branch_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

// Classifies one instruction word as conditional branch, direct jump or neither
module branch_decoder (
    input  wire bpred_pkg::instr_word_t instr,
    output logic                        is_branch,
    output logic                        is_jump
);

    import bpred_pkg::*;

    logic is_cond;                          // Conditional branch of any form
    logic is_regimm_branch;                 // REGIMM word whose rt selects a branch

    // REGIMM also carries the trap-immediate group, so rt must be checked
    always_comb begin
        case (instr.i_fields.rt)
            RT_BLTZ,
            RT_BGEZ,
            RT_BLTZAL,
            RT_BGEZAL: is_regimm_branch = 1'b1;
            default:   is_regimm_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (instr.i_fields.opcode)
            OP_BEQ,
            OP_BNE,
            OP_BLEZ,
            OP_BGTZ:   is_cond = 1'b1;
            OP_REGIMM: is_cond = is_regimm_branch;
            default:   is_cond = 1'b0;
        endcase
    end

    // Direct jumps are read through the J-type view of the same word
    assign is_jump = (instr.j_fields.opcode == OP_J) ||
                     (instr.j_fields.opcode == OP_JAL);

    // PHT and BTB treat both kinds alike
    assign is_branch = is_cond | is_jump;

endmodule

`default_nettype wire

/* hw/branch_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// Direct-mapped tagged store of branch targets
module branch_target_buffer #(
    parameter int BTB_INDEX_BITS = 6
) (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   lookup_en,
    input  wire bpred_pkg::addr_t lookup_addr,
    output logic                  hit,
    output bpred_pkg::addr_t      target,
    input  wire                   write_en,
    input  wire bpred_pkg::addr_t write_addr,
    input  wire bpred_pkg::addr_t write_target
);

    import bpred_pkg::*;

    localparam int BTB_ENTRIES = 1 << BTB_INDEX_BITS;
    localparam int TAG_BITS    = 32 - BTB_INDEX_BITS - 2;

    logic [BTB_ENTRIES-1:0]    valid;
    logic [TAG_BITS-1:0]       tags    [BTB_ENTRIES];
    addr_t                     targets [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic [BTB_INDEX_BITS-1:0] write_idx;
    logic [TAG_BITS-1:0]       write_tag;
    logic                      tag_match;

    // Index sits just above the byte offset, the tag takes everything above it
    assign lookup_idx = lookup_addr[BTB_INDEX_BITS+1:2];
    assign lookup_tag = lookup_addr[31:BTB_INDEX_BITS+2];
    assign write_idx  = write_addr[BTB_INDEX_BITS+1:2];
    assign write_tag  = write_addr[31:BTB_INDEX_BITS+2];

    assign tag_match = (tags[lookup_idx] == lookup_tag);

    // An aliasing PC with another tag must not pick up a stranger's target
    assign hit = lookup_en & valid[lookup_idx] & tag_match;

    assign target = hit ? targets[lookup_idx] : '0;

    // Only the valid bits need clearing, stale tags are masked by them
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid <= '0;
        end else if (write_en) begin
            valid[write_idx] <= 1'b1;
        end
    end

    // Tag and target payload
    always_ff @(posedge CLK) begin
        if (write_en) begin
            tags[write_idx]    <= write_tag;
            targets[write_idx] <= write_target;  // Newest taken target replaces the old one
        end
    end

endmodule

`default_nettype wire

/* hw/pattern_history_table.sv */
`timescale 1ns/1ps
`default_nettype none

// Table of 2-bit saturating counters indexed by the low PC bits
module pattern_history_table #(
    parameter int PHT_INDEX_BITS = 8
) (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   lookup_en,
    input  wire bpred_pkg::addr_t lookup_addr,
    output logic                  predict_taken,
    input  wire                   update_en,
    input  wire bpred_pkg::addr_t update_addr,
    input  wire                   update_taken
);

    import bpred_pkg::*;

    localparam int PHT_ENTRIES = 1 << PHT_INDEX_BITS;

    counter_t                  counters [PHT_ENTRIES];
    logic [PHT_INDEX_BITS-1:0] lookup_idx;
    logic [PHT_INDEX_BITS-1:0] update_idx;
    counter_t                  update_cur;     // Counter being trained this cycle
    counter_t                  update_next;

    // Instructions are word aligned, so bits 1:0 carry no information
    assign lookup_idx = lookup_addr[PHT_INDEX_BITS+1:2];
    assign update_idx = update_addr[PHT_INDEX_BITS+1:2];

    // Read before the edge, so a training write shows up one cycle later
    assign predict_taken = lookup_en & counters[lookup_idx][1];

    assign update_cur = counters[update_idx];

    // Move one step toward the outcome and stick at either end
    always_comb begin
        if (update_taken) begin
            if (update_cur == CNT_STRONG_T) begin
                update_next = CNT_STRONG_T;
            end else begin
                update_next = update_cur + 2'd1;
            end
        end else begin
            if (update_cur == CNT_STRONG_NT) begin
                update_next = CNT_STRONG_NT;
            end else begin
                update_next = update_cur - 2'd1;
            end
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                counters[i] <= CNT_RESET;      // Every entry starts weakly not taken
            end
        end else if (update_en) begin
            counters[update_idx] <= update_next;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the bimodal predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing \
    --top-module tb_bimodal_predictor \
    -f bimodal_predictor.f \
    -o tb_bimodal_predictor

./obj_dir/tb_bimodal_predictor > "$LOG" 2>&1
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

if ! grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG"
    exit 1
fi

echo "Simulation passed"

/* sim/tb_bimodal_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bimodal_predictor;

    import bpred_pkg::*;

    localparam int PHT_INDEX_BITS = 8;
    localparam int BTB_INDEX_BITS = 6;
    localparam int PHT_ENTRIES    = 1 << PHT_INDEX_BITS;
    localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
    localparam int TAG_BITS       = 32 - BTB_INDEX_BITS - 2;

    logic        CLK;
    logic        RESET;
    logic        flush;
    instr_word_t instr;
    addr_t       instr_addr;
    instr_word_t resolved_instr;
    addr_t       resolved_addr;
    logic        resolved_taken;
    addr_t       resolved_target;
    logic        taken;
    addr_t       taken_addr;

    counter_t            ref_cnt    [PHT_ENTRIES];  // Expected counter per PHT entry
    logic                ref_valid  [BTB_ENTRIES];
    logic [TAG_BITS-1:0] ref_tag    [BTB_ENTRIES];
    addr_t               ref_target [BTB_ENTRIES];

    integer seed;
    int     error_count;
    int     check_count;
    int     next_slot;                              // Gives every test PC its own table entries

    bimodal_predictor #(
        .PHT_INDEX_BITS (PHT_INDEX_BITS),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) dut0 (
        .CLK             (CLK),
        .RESET           (RESET),
        .flush           (flush),
        .instr           (instr),
        .instr_addr      (instr_addr),
        .resolved_instr  (resolved_instr),
        .resolved_addr   (resolved_addr),
        .resolved_taken  (resolved_taken),
        .resolved_target (resolved_target),
        .taken           (taken),
        .taken_addr      (taken_addr)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        #20000;
        $display("Watchdog expired before the directed tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic check_taken(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic instr_word_t cond_branch_word(input opcode_t op, input logic [15:0] offset);
        instr_word_t w;
        w = '0;
        w.i_fields.opcode = op;
        w.i_fields.rs     = 5'd3;
        w.i_fields.rt     = 5'd4;
        w.i_fields.imm    = offset;
        return w;
    endfunction

    function automatic instr_word_t jump_word(input opcode_t op, input addr_t dest);
        instr_word_t w;
        w = '0;
        w.j_fields.opcode = op;
        w.j_fields.index  = dest[27:2];
        return w;
    endfunction

    function automatic instr_word_t add_word();
        instr_word_t w;
        w = 32'h0043_2020;                          // add $4, $2, $3
        return w;
    endfunction

    function automatic addr_t fresh_pc();
        addr_t rnd;
        rnd = $random(seed);
        next_slot++;
        return {rnd[31:10], next_slot[7:0], 2'b00};
    endfunction

    function automatic addr_t rand_target();
        addr_t rnd;
        rnd = $random(seed);
        return {rnd[31:2], 2'b00};
    endfunction

    function automatic logic is_direct_jump(input instr_word_t w);
        return (w.j_fields.opcode == OP_J) || (w.j_fields.opcode == OP_JAL);
    endfunction

    // The REGIMM forms are never driven, so the plain branch opcodes suffice
    function automatic logic tracked_branch(input instr_word_t w);
        return is_direct_jump(w) ||
               (w.i_fields.opcode inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ});
    endfunction

    task automatic clear_model();
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            ref_cnt[i] = CNT_RESET;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    task automatic expected_prediction(input instr_word_t w, input addr_t pc,
                                       output logic exp_taken, output addr_t exp_addr);
        logic [PHT_INDEX_BITS-1:0] pi;
        logic [BTB_INDEX_BITS-1:0] bi;
        logic                      hit;
        pi = pc[PHT_INDEX_BITS+1:2];
        bi = pc[BTB_INDEX_BITS+1:2];
        hit = tracked_branch(w) && ref_valid[bi] && (ref_tag[bi] == pc[31:BTB_INDEX_BITS+2]);
        exp_taken = hit && (is_direct_jump(w) || ref_cnt[pi][1]);  // Jumps skip the counter
        exp_addr  = hit ? ref_target[bi] : '0;
    endtask

    task automatic update_model(input instr_word_t w, input addr_t pc,
                                input logic tk, input addr_t tgt);
        logic [PHT_INDEX_BITS-1:0] pi;
        logic [BTB_INDEX_BITS-1:0] bi;
        pi = pc[PHT_INDEX_BITS+1:2];
        bi = pc[BTB_INDEX_BITS+1:2];
        if (tracked_branch(w)) begin
            if (tk && ref_cnt[pi] != CNT_STRONG_T) begin
                ref_cnt[pi] = ref_cnt[pi] + 2'd1;
            end else if (!tk && ref_cnt[pi] != CNT_STRONG_NT) begin
                ref_cnt[pi] = ref_cnt[pi] - 2'd1;
            end
            if (tk) begin
                ref_valid[bi]  = 1'b1;
                ref_tag[bi]    = pc[31:BTB_INDEX_BITS+2];
                ref_target[bi] = tgt;
            end
        end
    endtask

    // Drives one fetch and one resolution, then checks the prediction after the edge
    task automatic run_cycle(input instr_word_t f_instr, input addr_t f_addr,
                             input instr_word_t r_instr, input addr_t r_addr,
                             input logic r_taken, input addr_t r_target, input logic do_flush);
        logic  exp_taken;
        addr_t exp_addr;
        instr           = f_instr;
        instr_addr      = f_addr;
        resolved_instr  = r_instr;
        resolved_addr   = r_addr;
        resolved_taken  = r_taken;
        resolved_target = r_target;
        flush           = do_flush;
        expected_prediction(f_instr, f_addr, exp_taken, exp_addr);
        if (do_flush) begin
            exp_taken = 1'b0;
            exp_addr  = '0;
        end
        update_model(r_instr, r_addr, r_taken, r_target);
        @(posedge CLK);
        #1;
        check_taken("taken", exp_taken, taken);
        check_addr("taken_addr", exp_addr, taken_addr);
    endtask

    task automatic train(input instr_word_t w, input addr_t pc, input logic tk, input addr_t tgt);
        run_cycle(add_word(), '0, w, pc, tk, tgt, 1'b0);
    endtask

    task automatic predict(input instr_word_t w, input addr_t pc);
        run_cycle(w, pc, add_word(), '0, 1'b0, '0, 1'b0);
    endtask

    task automatic reset_predicts_nothing();
        for (int i = 0; i < 4; i++) begin
            predict(cond_branch_word(OP_BEQ, 16'h0010), fresh_pc());
            check_taken("taken", 1'b0, taken);
            check_addr("taken_addr", '0, taken_addr);
        end
    endtask

    task automatic training_sets_prediction();
        addr_t pc;
        addr_t tgt;
        pc  = fresh_pc();
        tgt = rand_target();
        train(cond_branch_word(OP_BEQ, 16'h0020), pc, 1'b1, tgt);
        predict(cond_branch_word(OP_BEQ, 16'h0020), pc);
        check_taken("taken", 1'b1, taken);
        check_addr("taken_addr", tgt, taken_addr);
        pc = fresh_pc();
        train(cond_branch_word(OP_BNE, 16'hfff0), pc, 1'b0, rand_target());
        predict(cond_branch_word(OP_BNE, 16'hfff0), pc);
        check_taken("taken", 1'b0, taken);
    endtask

    task automatic hysteresis_holds();
        addr_t pc;
        addr_t tgt;
        pc  = fresh_pc();
        tgt = rand_target();
        repeat (3) train(cond_branch_word(OP_BLEZ, 16'h0008), pc, 1'b1, tgt);
        train(cond_branch_word(OP_BLEZ, 16'h0008), pc, 1'b0, tgt);
        predict(cond_branch_word(OP_BLEZ, 16'h0008), pc);
        check_taken("taken", 1'b1, taken);         // Strong state survives one miss
        train(cond_branch_word(OP_BLEZ, 16'h0008), pc, 1'b0, tgt);
        predict(cond_branch_word(OP_BLEZ, 16'h0008), pc);
        check_taken("taken", 1'b0, taken);
    endtask

    task automatic gating_filters();
        addr_t pc;
        addr_t tgt;
        pc  = fresh_pc();
        tgt = rand_target();
        train(cond_branch_word(OP_BGTZ, 16'h0040), pc, 1'b1, tgt);
        predict(add_word(), pc);
        check_taken("taken", 1'b0, taken);
        check_addr("taken_addr", '0, taken_addr);
        repeat (2) train(add_word(), pc, 1'b0, rand_target());
        train(add_word(), pc, 1'b1, rand_target());   // Would overwrite the target if not gated
        predict(cond_branch_word(OP_BGTZ, 16'h0040), pc);
        check_taken("taken", 1'b1, taken);
        check_addr("taken_addr", tgt, taken_addr);
        pc  = fresh_pc();
        tgt = rand_target();
        train(jump_word(OP_J, tgt), pc, 1'b0, tgt);  // Counter drops to strongly not taken
        train(jump_word(OP_J, tgt), pc, 1'b1, tgt);
        predict(jump_word(OP_J, tgt), pc);
        check_taken("taken", 1'b1, taken);
        check_addr("taken_addr", tgt, taken_addr);
    endtask

    task automatic tag_mismatch_misses();
        addr_t pc;
        addr_t tgt;
        pc  = fresh_pc();
        tgt = rand_target();
        train(cond_branch_word(OP_BEQ, 16'h0100), pc, 1'b1, tgt);
        predict(cond_branch_word(OP_BEQ, 16'h0100), pc ^ 32'h8000_0000);  // Same index, other tag
        check_taken("taken", 1'b0, taken);
        check_addr("taken_addr", '0, taken_addr);
        predict(cond_branch_word(OP_BEQ, 16'h0100), pc);
        check_taken("taken", 1'b1, taken);
    endtask

    task automatic flush_clears_outputs();
        addr_t pc;
        addr_t tgt;
        addr_t pc2;
        addr_t tgt2;
        pc   = fresh_pc();
        tgt  = rand_target();
        pc2  = fresh_pc();
        tgt2 = rand_target();
        train(cond_branch_word(OP_BNE, 16'h0004), pc, 1'b1, tgt);
        predict(cond_branch_word(OP_BNE, 16'h0004), pc);
        check_taken("taken", 1'b1, taken);
        // The resolution in the flushed cycle still trains pc2
        run_cycle(cond_branch_word(OP_BNE, 16'h0004), pc,
                  cond_branch_word(OP_BEQ, 16'h0004), pc2, 1'b1, tgt2, 1'b1);
        check_taken("taken", 1'b0, taken);
        check_addr("taken_addr", '0, taken_addr);
        predict(cond_branch_word(OP_BNE, 16'h0004), pc);
        check_taken("taken", 1'b1, taken);
        check_addr("taken_addr", tgt, taken_addr);
        predict(cond_branch_word(OP_BEQ, 16'h0004), pc2);
        check_taken("taken", 1'b1, taken);
        check_addr("taken_addr", tgt2, taken_addr);
    endtask

    initial begin
        seed            = 32'hc75b877b;
        error_count     = 0;
        check_count     = 0;
        next_slot       = 0;
        RESET           = 1'b0;
        flush           = 1'b0;
        instr           = add_word();
        instr_addr      = '0;
        resolved_instr  = add_word();
        resolved_addr   = '0;
        resolved_taken  = 1'b0;
        resolved_target = '0;
        clear_model();
        repeat (10) @(posedge CLK);
        #1;
        RESET = 1'b1;
        reset_predicts_nothing();
        training_sets_prediction();
        hysteresis_holds();
        gating_filters();
        tag_mismatch_misses();
        flush_clears_outputs();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
